//--- mac_defs.svh
`ifndef MAC_DEFS_SVH
`define MAC_DEFS_SVH

// Width of one lane, the smallest operand the unit multiplies
`define MAC_MIN_WIDTH 8

// Number of lanes that can be combined into wider groups
`define MAC_LANES 4

// Full operand width across all lanes
`define MAC_OP_WIDTH (`MAC_MIN_WIDTH * `MAC_LANES)

// Result width, four lanes of 32 bits each
`define MAC_ACC_WIDTH (4 * `MAC_OP_WIDTH)

// Result bits owned by a single lane
`define MAC_LANE_RES_WIDTH (`MAC_ACC_WIDTH / `MAC_LANES)

// One lane-pair partial product
`define MAC_PP_WIDTH (2 * `MAC_MIN_WIDTH)

`endif

//--- mac_pkg.sv
`default_nettype none

`include "mac_defs.svh"

package mac_pkg;

  // Group size is 1, 2 or 4 lanes
  typedef enum logic [1:0] {
    MODE_SINGLE = 2'd0,
    MODE_DUAL   = 2'd1,
    MODE_QUAD   = 2'd2
  } mac_mode_e;

  // Sign bit on top, then MAC/MUL select, mode in the two low bits
  typedef struct packed {
    logic      is_signed;
    logic      accumulate;
    mac_mode_e mode;
  } mac_cfg_t;

  typedef struct packed {
    mac_cfg_t                   cfg;
    logic                       clear;
    logic [`MAC_OP_WIDTH-1:0]   mag_a;
    logic [`MAC_OP_WIDTH-1:0]   mag_b;
    logic [`MAC_LANES-1:0]      neg;
  } mac_opnd_t;

  typedef struct packed {
    mac_cfg_t                   cfg;
    logic                       clear;
    logic [`MAC_ACC_WIDTH-1:0]  prod;
    logic [`MAC_LANES-1:0]      neg;
  } mac_prod_t;

  // Lane index bits that name the group; lanes with equal masked index share a group.
  // The unused encoding behaves as single mode
  function automatic logic [1:0] mac_group_mask(input mac_mode_e mode);
    case (mode)
      MODE_DUAL: return 2'b10;
      MODE_QUAD: return 2'b00;
      default:   return 2'b11;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- mac_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mac_stage_if import mac_pkg::*; #(
  parameter type T = mac_opnd_t
) ();

  logic     valid;
  logic     ready;
  mac_cfg_t cfg;
  T         data;

  // Source holds valid, cfg and data until the sink raises ready
  modport source (output valid, output cfg, output data, input ready);
  modport sink (input valid, input cfg, input data, output ready);

endinterface

`default_nettype wire

//--- n_bit_cla_adder.sv
`timescale 1ns/1ps
`default_nettype none

module n_bit_cla_adder #(
  parameter int N = 8
) (
  input  logic [N-1:0] a,
  input  logic [N-1:0] b,
  input  logic         cin,
  output logic [N-1:0] sum,
  output logic         cout
);

  logic [N-1:0] gen;
  logic [N-1:0] prop;
  logic [N:0]   carry;

  assign gen  = a & b;
  assign prop = a ^ b;

  // Each carry is expanded from the generate and propagate terms of all lower bits
  always_comb begin
    logic term;
    carry[0] = cin;
    for (int i = 0; i < N; i++) begin
      carry[i+1] = cin;
      for (int k = 0; k <= i; k++) begin
        carry[i+1] = carry[i+1] & prop[k];
      end
      for (int k = 0; k <= i; k++) begin
        term = gen[k];
        for (int m = k + 1; m <= i; m++) begin
          term = term & prop[m];
        end
        carry[i+1] = carry[i+1] | term;
      end
    end
  end

  assign sum  = prop ^ carry[N-1:0];
  assign cout = carry[N];

endmodule

`default_nettype wire

//--- mac_mul_negator_block.sv
`timescale 1ns/1ps
`default_nettype none

`include "mac_defs.svh"

module mac_mul_negator_block import mac_pkg::*; (
  input  mac_cfg_t                 cfg,
  input  logic [`MAC_OP_WIDTH-1:0] a_in,
  input  logic [`MAC_OP_WIDTH-1:0] b_in,
  output logic [`MAC_OP_WIDTH-1:0] a_out,
  output logic [`MAC_OP_WIDTH-1:0] b_out,
  output logic [`MAC_LANES-1:0]    neg
);

  localparam int W = `MAC_MIN_WIDTH;
  localparam int L = `MAC_LANES;

  logic [1:0]             gmask;
  logic [L-1:0]           a_msb;
  logic [L-1:0]           b_msb;
  logic [L-1:0]           a_cin;
  logic [L-1:0]           b_cin;
  logic [L-1:0]           a_cout;
  logic [L-1:0]           b_cout;
  logic [`MAC_OP_WIDTH-1:0] a_neg;
  logic [`MAC_OP_WIDTH-1:0] b_neg;

  assign gmask = mac_group_mask(cfg.mode);

  // Product sign per lane, the accumulator picks the top lane of each group
  assign neg = a_msb ^ b_msb;

  for (genvar l = 0; l < L; l++) begin : g_lane
    localparam logic [1:0] LANE = 2'(l);

    logic sel_a;
    logic sel_b;

    assign a_msb[l] = a_in[l*W + W-1];
    assign b_msb[l] = b_in[l*W + W-1];

    if (l == 0) begin : g_first
      assign a_cin[l] = 1'b1;
      assign b_cin[l] = 1'b1;
    end else begin : g_chain
      logic same_group;

      // Inside a group the +1 ripples up from the lane below; a new group restarts it
      assign same_group = (LANE & gmask) == ((LANE - 2'd1) & gmask);
      assign a_cin[l]   = same_group ? a_cout[l-1] : 1'b1;
      assign b_cin[l]   = same_group ? b_cout[l-1] : 1'b1;
    end

    n_bit_cla_adder #(
      .N(W)
    ) u_add_a (
      .a    (~a_in[l*W +: W]),
      .b    ('0),
      .cin  (a_cin[l]),
      .sum  (a_neg[l*W +: W]),
      .cout (a_cout[l])
    );

    n_bit_cla_adder #(
      .N(W)
    ) u_add_b (
      .a    (~b_in[l*W +: W]),
      .b    ('0),
      .cin  (b_cin[l]),
      .sum  (b_neg[l*W +: W]),
      .cout (b_cout[l])
    );

    // The sign of the whole group sits in its top lane
    assign sel_a = cfg.is_signed & a_msb[LANE | ~gmask];
    assign sel_b = cfg.is_signed & b_msb[LANE | ~gmask];

    assign a_out[l*W +: W] = sel_a ? a_neg[l*W +: W] : a_in[l*W +: W];
    assign b_out[l*W +: W] = sel_b ? b_neg[l*W +: W] : b_in[l*W +: W];
  end

endmodule

`default_nettype wire

//--- mac_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module mac_pipe_reg import mac_pkg::*; #(
  parameter type T = mac_opnd_t
) (
  input  logic        clk,
  input  logic        rst_n,
  mac_stage_if.sink   up,
  mac_stage_if.source dn
);

  logic     valid_q;
  mac_cfg_t cfg_q;
  T         data_q;

  // Accept when empty or when the held beat leaves in the same cycle
  assign up.ready = !valid_q || dn.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (up.ready) begin
      valid_q <= up.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (up.ready && up.valid) begin
      cfg_q  <= up.cfg;
      data_q <= up.data;
    end
  end

  assign dn.valid = valid_q;
  assign dn.cfg   = cfg_q;
  assign dn.data  = data_q;

endmodule

`default_nettype wire

//--- mac_product_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "mac_defs.svh"

module mac_product_array import mac_pkg::*; (
  mac_stage_if.sink   opnd,
  mac_stage_if.source prod
);

  localparam int W  = `MAC_MIN_WIDTH;
  localparam int L  = `MAC_LANES;
  localparam int RW = `MAC_ACC_WIDTH;

  logic [`MAC_PP_WIDTH-1:0] pp [L][L];
  logic [1:0]               gmask;
  logic [RW-1:0]            prod_sum;
  mac_opnd_t                opnd_beat;
  mac_prod_t                prod_beat;

  assign opnd_beat = opnd.data;
  assign gmask     = mac_group_mask(opnd.cfg.mode);

  // Every lane pair is multiplied, the mode only decides which pairs are kept
  always_comb begin
    for (int i = 0; i < L; i++) begin
      for (int j = 0; j < L; j++) begin
        pp[i][j] = opnd_beat.mag_a[i*W +: W] * opnd_beat.mag_b[j*W +: W];
      end
    end
  end

  // A pair inside group base b lands at 8*(i+j) + 16*b, which puts the group product
  // at the bottom of its 32-bit-per-lane result field
  always_comb begin
    logic [1:0] li;
    logic [1:0] lj;
    prod_sum = '0;
    for (int i = 0; i < L; i++) begin
      for (int j = 0; j < L; j++) begin
        li = 2'(i);
        lj = 2'(j);
        if ((li & gmask) == (lj & gmask)) begin
          prod_sum = prod_sum + (RW'(pp[i][j]) << (W * (i + j) + 2 * W * int'(li & gmask)));
        end
      end
    end
  end

  always_comb begin
    prod_beat.cfg   = opnd.cfg;
    prod_beat.clear = opnd_beat.clear;
    prod_beat.prod  = prod_sum;
    prod_beat.neg   = opnd_beat.neg;
  end

  assign prod.valid = opnd.valid;
  assign prod.cfg   = opnd.cfg;
  assign prod.data  = prod_beat;
  assign opnd.ready = prod.ready;

endmodule

`default_nettype wire

//--- mac_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

`include "mac_defs.svh"

module mac_accumulator import mac_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  mac_stage_if.sink                 prod,
  output logic                      out_valid,
  input  logic                      out_ready,
  output logic [`MAC_ACC_WIDTH-1:0] out_result
);

  localparam int L  = `MAC_LANES;
  localparam int LW = `MAC_LANE_RES_WIDTH;
  localparam int RW = `MAC_ACC_WIDTH;

  logic [1:0]    gmask;
  logic          out_valid_q;
  logic          take;
  logic [RW-1:0] acc_q;
  logic [RW-1:0] acc_next;
  mac_prod_t     beat;

  assign beat       = prod.data;
  assign gmask      = mac_group_mask(prod.cfg.mode);
  assign prod.ready = !out_valid_q || out_ready;
  assign take       = prod.valid && prod.ready;

  // Work on full-width masked copies so each group wraps inside its own field
  always_comb begin
    logic [RW-1:0] field_mask;
    logic [RW-1:0] mag;
    logic [RW-1:0] signed_prod;
    logic [RW-1:0] new_field;
    logic [1:0]    top;
    acc_next = acc_q;
    for (int g = 0; g < L; g++) begin
      if ((2'(g) & gmask) == 2'(g)) begin
        field_mask = '0;
        for (int k = 0; k < L; k++) begin
          if ((2'(k) & gmask) == 2'(g)) begin
            field_mask[k*LW +: LW] = '1;
          end
        end
        top = 2'(g) | ~gmask;
        mag = beat.prod & field_mask;
        // Bits below the field are zero, so the masked negation is the field's own
        signed_prod = (prod.cfg.is_signed && beat.neg[top]) ? (-mag) & field_mask : mag;
        if (beat.clear || !prod.cfg.accumulate) begin
          new_field = signed_prod;
        end else begin
          new_field = ((acc_q & field_mask) + signed_prod) & field_mask;
        end
        acc_next = (acc_next & ~field_mask) | new_field;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_q <= 1'b0;
      acc_q       <= '0;
    end else begin
      if (prod.ready) begin
        out_valid_q <= prod.valid;
      end
      if (take) begin
        acc_q <= acc_next;
      end
    end
  end

  assign out_valid  = out_valid_q;
  assign out_result = acc_q;

endmodule

`default_nettype wire

//--- mac_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mac_defs.svh"

module mac_unit import mac_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  mac_cfg_t                  in_cfg,
  input  logic                      in_clear,
  input  logic [`MAC_OP_WIDTH-1:0]  in_a,
  input  logic [`MAC_OP_WIDTH-1:0]  in_b,
  output logic                      out_valid,
  input  logic                      out_ready,
  output logic [`MAC_ACC_WIDTH-1:0] out_result
);

  logic [`MAC_OP_WIDTH-1:0] mag_a;
  logic [`MAC_OP_WIDTH-1:0] mag_b;
  logic [`MAC_LANES-1:0]    neg;
  mac_opnd_t                opnd_beat;

  // Stage 0 side, the registered operand stage, the array output and the product stage
  mac_stage_if #(.T(mac_opnd_t)) in_if ();
  mac_stage_if #(.T(mac_opnd_t)) opnd_if ();
  mac_stage_if #(.T(mac_prod_t)) arr_if ();
  mac_stage_if #(.T(mac_prod_t)) prod_if ();

  mac_mul_negator_block u_negator (
    .cfg   (in_cfg),
    .a_in  (in_a),
    .b_in  (in_b),
    .a_out (mag_a),
    .b_out (mag_b),
    .neg   (neg)
  );

  assign opnd_beat = '{cfg: in_cfg, clear: in_clear, mag_a: mag_a, mag_b: mag_b, neg: neg};

  assign in_if.valid = in_valid;
  assign in_if.cfg   = in_cfg;
  assign in_if.data  = opnd_beat;
  assign in_ready    = in_if.ready;

  mac_pipe_reg #(.T(mac_opnd_t)) u_opnd_reg (
    .clk   (clk),
    .rst_n (rst_n),
    .up    (in_if),
    .dn    (opnd_if)
  );

  mac_product_array u_product_array (
    .opnd (opnd_if),
    .prod (arr_if)
  );

  mac_pipe_reg #(.T(mac_prod_t)) u_prod_reg (
    .clk   (clk),
    .rst_n (rst_n),
    .up    (arr_if),
    .dn    (prod_if)
  );

  mac_accumulator u_accumulator (
    .clk        (clk),
    .rst_n      (rst_n),
    .prod       (prod_if),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result)
  );

endmodule

`default_nettype wire

//--- mac_unit_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "mac_defs.svh"

module mac_unit_assert (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      in_valid,
  input logic                      in_ready,
  input logic                      out_valid,
  input logic                      out_ready,
  input logic [`MAC_ACC_WIDTH-1:0] out_result
);

  int fail_count = 0;
  int in_flight;

  // Beats accepted at the input and not yet delivered at the output
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(in_valid && in_ready) - int'(out_valid && out_ready);
    end
  end

  // The output register is cleared asynchronously, so no result shows while in reset
  a_reset_idle: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else begin
      fail_count++;
      $error("out_valid is high while reset is asserted");
    end

  // A result that waits for out_ready must not change or vanish
  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_result))
    else begin
      fail_count++;
      $error("stalled result changed before out_ready");
    end

  a_empty_ready: assert property (@(posedge clk) disable iff (!rst_n)
    in_flight == 0 |-> in_ready)
    else begin
      fail_count++;
      $error("in_ready is low while the pipe is empty");
    end

endmodule

`default_nettype wire

//--- mac_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "mac_defs.svh"

module mac_checker import mac_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      in_valid,
  input  logic                      in_ready,
  input  mac_cfg_t                  in_cfg,
  input  logic                      in_clear,
  input  logic [`MAC_OP_WIDTH-1:0]  in_a,
  input  logic [`MAC_OP_WIDTH-1:0]  in_b,
  input  logic                      out_valid,
  input  logic                      out_ready,
  input  logic [`MAC_ACC_WIDTH-1:0] out_result,
  output int                        value_errs,
  output int                        order_errs,
  output int                        latency_errs,
  output int                        pending
);

  typedef struct packed {
    mac_cfg_t    cfg;
    logic        clear;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] cyc;
  } beat_t;

  beat_t        beats[$];
  logic [127:0] model;
  logic [31:0]  cycle;
  logic [31:0]  last_stall;

  // Group g of size gs multiplies operand bits g*8*gs and owns result bits g*32*gs
  function automatic logic [127:0] apply_beat(input logic [127:0] acc, input beat_t bt);
    int           gs;
    int           ow;
    int           fw;
    logic [127:0] a_g;
    logic [127:0] b_g;
    logic [127:0] low;
    logic [127:0] field;
    logic [127:0] res;
    res = acc;
    gs = (bt.cfg.mode == MODE_QUAD) ? 4 : ((bt.cfg.mode == MODE_DUAL) ? 2 : 1);
    ow = 8 * gs;
    fw = 32 * gs;
    low = (fw == 128) ? ~128'd0 : (128'd1 << fw) - 128'd1;
    for (int g = 0; g < 4 / gs; g++) begin
      a_g = 128'(bt.a >> (g * ow)) & ((128'd1 << ow) - 128'd1);
      b_g = 128'(bt.b >> (g * ow)) & ((128'd1 << ow) - 128'd1);
      if (bt.cfg.is_signed && a_g[ow-1]) a_g = a_g | (~128'd0 << ow);
      if (bt.cfg.is_signed && b_g[ow-1]) b_g = b_g | (~128'd0 << ow);
      field = (a_g * b_g) & low;
      if (!bt.clear && bt.cfg.accumulate) begin
        field = (field + (acc >> (g * fw))) & low;
      end
      res = (res & ~(low << (g * fw))) | (field << (g * fw));
    end
    return res;
  endfunction

  always @(posedge clk) begin
    beat_t       bt;
    logic [31:0] lat;
    if (!rst_n) begin
      beats.delete();
      model = '0;
      cycle = '0;
      last_stall = '0;
      value_errs = 0;
      order_errs = 0;
      latency_errs = 0;
    end else begin
      cycle = cycle + 32'd1;
      if (!out_ready) last_stall = cycle;
      if (in_valid && in_ready) begin
        beats.push_back('{cfg: in_cfg, clear: in_clear, a: in_a, b: in_b, cyc: cycle});
      end
      if (out_valid && out_ready) begin
        if (beats.size() == 0) begin
          order_errs++;
          $display("%0t: output transfer with no accepted beat waiting for it", $time);
        end else begin
          bt = beats.pop_front();
          model = apply_beat(model, bt);
          if (out_result !== model) begin
            value_errs++;
            $display("ERROR time=%0t out_result expected=%h got=%h", $time, model, out_result);
          end
          lat = cycle - bt.cyc;
          // Without a stall since acceptance the beat must take exactly three edges
          if ((last_stall <= bt.cyc) ? (lat != 32'd3) : (lat < 32'd3)) begin
            latency_errs++;
            $display("ERROR time=%0t latency expected=3 got=%0d", $time, lat);
          end
        end
      end
    end
    pending = beats.size();
  end

endmodule

`default_nettype wire

//--- mac_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mac_defs.svh"

module mac_unit_tb import mac_pkg::*;;

  localparam logic [31:0] SEED       = 32'd31365;
  localparam int          WAIT_LIMIT = 200;

  logic                      clk;
  logic                      rst_n;
  logic                      in_valid;
  logic                      in_ready;
  mac_cfg_t                  in_cfg;
  logic                      in_clear;
  logic [`MAC_OP_WIDTH-1:0]  in_a;
  logic [`MAC_OP_WIDTH-1:0]  in_b;
  logic                      out_valid;
  logic                      out_ready;
  logic [`MAC_ACC_WIDTH-1:0] out_result;
  logic                      stall_en;
  logic [31:0]               rng_in;
  logic [31:0]               rng_out;
  int                        value_errs;
  int                        order_errs;
  int                        latency_errs;
  int                        pending;
  int                        timeout_errs;
  int                        total;

  mac_unit u_dut (.*);

  mac_checker u_chk (.*);

  bind mac_unit mac_unit_assert u_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic mac_mode_e pick_mode(input logic [2:0] r);
    if (r < 3'd3) return MODE_SINGLE;
    if (r < 3'd6) return MODE_DUAL;
    return MODE_QUAD;
  endfunction

  // Most negative lane, pair and word values show up often next to plain random words
  function automatic logic [31:0] pick_operand(input logic [31:0] r);
    case (r[2:0])
      3'd0:    return 32'h8080_8080;
      3'd1:    return 32'h8000_8000;
      3'd2:    return 32'h8000_0000;
      3'd3:    return 32'hffff_ffff;
      default: return r;
    endcase
  endfunction

  task automatic send_beat(input logic gaps);
    int waited;
    rng_in = xorshift32(rng_in);
    if (gaps && rng_in[1:0] == 2'd0) begin
      in_valid <= 1'b0;
      @(posedge clk);
    end
    rng_in = xorshift32(rng_in);
    in_cfg   <= '{is_signed: rng_in[0], accumulate: rng_in[1], mode: pick_mode(rng_in[10:8])};
    in_clear <= (rng_in[6:4] == 3'd0);
    rng_in = xorshift32(rng_in);
    in_a <= pick_operand(rng_in);
    rng_in = xorshift32(rng_in);
    in_b <= pick_operand(rng_in);
    in_valid <= 1'b1;
    waited = 0;
    @(posedge clk);
    while (!in_ready && waited < WAIT_LIMIT) begin
      waited++;
      @(posedge clk);
    end
    if (!in_ready) begin
      timeout_errs++;
      $display("%0t: in_ready stayed low for %0d cycles", $time, WAIT_LIMIT);
    end
  endtask

  task automatic drain_pipe();
    int waited;
    waited = 0;
    @(negedge clk);
    while (pending != 0 && waited < WAIT_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    if (pending != 0) begin
      timeout_errs++;
      $display("%0t: pipe did not drain, %0d beats never came out", $time, pending);
    end
    repeat (4) @(negedge clk);
  endtask

  // Random out_ready stalls come from their own generator
  always @(posedge clk) begin
    if (stall_en) begin
      rng_out = xorshift32(rng_out);
      out_ready <= (rng_out[2:0] > 3'd2);
    end else begin
      out_ready <= 1'b1;
    end
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_cfg = '0;
    in_clear = 1'b0;
    in_a = '0;
    in_b = '0;
    out_ready = 1'b1;
    stall_en = 1'b0;
    timeout_errs = 0;
    rng_in = SEED;
    rng_out = xorshift32(~SEED);
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    // Back-to-back beats with no stalls, where the latency is fixed
    for (int i = 0; i < 60; i++) send_beat(1'b0);
    stall_en <= 1'b1;
    for (int i = 0; i < 600; i++) send_beat(1'b1);
    in_valid <= 1'b0;
    stall_en <= 1'b0;
    drain_pipe();
    total = value_errs + order_errs + latency_errs + u_dut.u_assert.fail_count + timeout_errs;
    $display("errors: value %0d, order %0d, latency %0d, assertion %0d, timeout %0d",
             value_errs, order_errs, latency_errs, u_dut.u_assert.fail_count, timeout_errs);
    if (total == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+.
mac_pkg.sv
mac_stage_if.sv
n_bit_cla_adder.sv
mac_mul_negator_block.sv
mac_pipe_reg.sv
mac_product_array.sv
mac_accumulator.sv
mac_unit.sv
mac_unit_assert.sv
mac_checker.sv
mac_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mac_unit_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
